/* lmsFilter.f */
design/lmsPkg.sv
design/lmsTap.sv
design/lmsTapGroup.sv
design/lmsErrorUnit.sv
design/lmsFilter.sv
verif/lmsFilterChecker.sv
verif/lmsFilterTb.sv

/* run.sh */
#!/bin/sh
# Build and run the LMS filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f lmsFilter.f --top-module lmsFilterTb -o lmsFilterSim

output=$(./obj_dir/lmsFilterSim)
echo "$output"

if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1

/* verif/lmsFilterTb.sv */
`default_nettype none

module lmsFilterTb import lmsPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IdentLength   = 400;
	localparam int WindowLength  = 50;
	localparam int RunLength     = 150;
	localparam int ResultTimeout = 20;

	// Unknown system for identification, Q1.15
	localparam longint Plant [TapCount] = '{
		3000, -2000, 1500, 800, -600, 400, 300, -200,
		150, 100, -80, 60, 50, -40, 30, 20
	};

	logic                          clk;
	logic                          rst;
	logic                          enable;
	logic signed [SampleWidth-1:0] sampleIn;
	logic signed [SampleWidth-1:0] desiredIn;
	logic signed [SampleWidth-1:0] stepSize;
	logic signed [SampleWidth-1:0] filterOut;
	logic signed [SampleWidth-1:0] errorOut;
	logic                          outValid;
	logic                          zeroCheck;
	int                            checkErrors;
	int                            resultCount;

	int     localErrors  = 0;
	int     failedTests  = 0;
	int     testsRun     = 0;
	int     errorsBefore = 0;
	logic   collect      = 1'b0;
	longint history [TapCount];
	longint absErrors [$];

	lmsFilter dut (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.sampleIn  (sampleIn),
		.desiredIn (desiredIn),
		.stepSize  (stepSize),
		.filterOut (filterOut),
		.errorOut  (errorOut),
		.outValid  (outValid)
	);

	lmsFilterChecker checkUnit (
		.clk         (clk),
		.rst         (rst),
		.enable      (enable),
		.sampleIn    (sampleIn),
		.desiredIn   (desiredIn),
		.stepSize    (stepSize),
		.filterOut   (filterOut),
		.errorOut    (errorOut),
		.outValid    (outValid),
		.zeroCheck   (zeroCheck),
		.errorCount  (checkErrors),
		.resultCount (resultCount)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Error magnitudes for the convergence measure
	always @(negedge clk) begin
		if (collect && outValid) begin
			absErrors.push_back(errorOut < 0 ? -longint'(errorOut) : longint'(errorOut));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic longint randSample(input int span);
		return longint'($urandom_range(2 * span, 0)) - span;
	endfunction

	// Plant output over the newest input, clipped to a sample
	function automatic longint plantOutput(input longint sample);
		longint acc;
		for (int k = TapCount - 1; k > 0; k--) begin
			history[k] = history[k-1];
		end
		history[0] = sample;
		acc = 0;
		for (int k = 0; k < TapCount; k++) begin
			acc += Plant[k] * history[k];
		end
		acc = acc >>> FracBits;
		return (acc > 32767) ? 32767 : ((acc < -32768) ? -32768 : acc);
	endfunction

	task automatic driveSample(input logic en, input logic zero, input longint sample,
		input longint desired);
		@(posedge clk);
		#1;
		enable    = en;
		zeroCheck = zero;
		sampleIn  = sample[SampleWidth-1:0];
		desiredIn = desired[SampleWidth-1:0];
	endtask

	task automatic applyReset();
		@(posedge clk);
		#1;
		rst    = 1'b1;
		enable = 1'b0;
		for (int k = 0; k < TapCount; k++) begin
			history[k] = 0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic waitForResult();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (outValid !== 1'b1 && cycles < ResultTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (outValid !== 1'b1) begin
			$display("Timed out waiting for outValid after %0d cycles", ResultTimeout);
			localErrors++;
		end
	endtask

	// Stop enabling and let the last result go by
	task automatic drainResults();
		int cycles;
		cycles = 0;
		driveSample(1'b0, 1'b0, 0, 0);
		@(negedge clk);
		while (outValid !== 1'b0 && cycles < ResultTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (outValid !== 1'b0) begin
			$display("Timed out waiting for outValid to fall");
			localErrors++;
		end
		@(negedge clk);
		#1;
	endtask

	task automatic reportTest(input string name);
		int found;
		found = checkErrors + localErrors - errorsBefore;
		testsRun++;
		if (found == 0) begin
			$display("Test %s: passed", name);
		end else begin
			failedTests++;
			$display("Test %s: failed with %0d errors", name, found);
		end
		errorsBefore = checkErrors + localErrors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic testReset();
		applyReset();
		stepSize = 16'sd8192;
		for (int n = 0; n < 8; n++) begin
			driveSample(1'b0, 1'b0, randSample(32767), randSample(32767));
		end
		driveSample(1'b1, 1'b1, randSample(32767), randSample(32767));
		driveSample(1'b0, 1'b0, 0, 0);
		waitForResult();
		drainResults();
		reportTest("reset");
	endtask

	task automatic testIdentification();
		longint firstSum;
		longint lastSum;
		longint sample;
		firstSum = 0;
		lastSum  = 0;
		applyReset();
		stepSize = 16'sd8192;
		absErrors.delete();
		collect = 1'b1;
		for (int n = 0; n < IdentLength; n++) begin
			sample = randSample(16384);
			driveSample(1'b1, 1'b0, sample, plantOutput(sample));
		end
		drainResults();
		collect = 1'b0;
		if (absErrors.size() != IdentLength) begin
			$display("Captured %0d results instead of %0d", absErrors.size(), IdentLength);
			localErrors++;
		end else begin
			for (int n = 0; n < WindowLength; n++) begin
				firstSum += absErrors[n];
				lastSum  += absErrors[IdentLength - WindowLength + n];
			end
			if (lastSum * 10 >= firstSum) begin
				$display("Filter did not converge, late error sum %0d against early %0d",
					lastSum, firstSum);
				localErrors++;
			end
		end
		reportTest("system identification");
	endtask

	task automatic testZeroStep();
		applyReset();
		stepSize = '0;
		for (int n = 0; n < RunLength; n++) begin
			driveSample(1'b1, 1'b1, randSample(32767), randSample(32767));
		end
		drainResults();
		reportTest("zero step size");
	endtask

	task automatic testSparseEnable();
		longint sample;
		applyReset();
		stepSize = 16'sd8192;
		for (int n = 0; n < 2 * RunLength; n++) begin
			sample = randSample(16384);
			driveSample($urandom_range(1, 0) == 1, 1'b0, sample, plantOutput(sample));
		end
		drainResults();
		reportTest("sparse enable");
	endtask

	task automatic testSaturation();
		longint sample;
		longint desired;
		applyReset();
		stepSize = SampleMax;
		for (int n = 0; n < RunLength; n++) begin
			sample  = ($urandom_range(1, 0) == 1) ? 32767 : -32768;
			desired = ($urandom_range(1, 0) == 1) ? 32767 : -32768;
			driveSample(1'b1, 1'b0, sample, desired);
		end
		drainResults();
		reportTest("saturation");
	endtask

	task automatic testMidRunReset();
		longint sample;
		applyReset();
		stepSize = 16'sd8192;
		for (int n = 0; n < RunLength; n++) begin
			sample = randSample(16384);
			driveSample(1'b1, 1'b0, sample, plantOutput(sample));
		end
		// Reset lands while samples keep coming
		for (int n = 0; n < 5; n++) begin
			driveSample(1'b1, 1'b0, randSample(16384), randSample(16384));
			rst = 1'b1;
		end
		driveSample(1'b1, 1'b1, randSample(32767), randSample(32767));
		rst = 1'b0;
		driveSample(1'b0, 1'b0, 0, 0);
		waitForResult();
		drainResults();
		reportTest("reset mid-run");
	endtask

	initial begin
		int totalErrors;
		rst       = 1'b1;
		enable    = 1'b0;
		sampleIn  = '0;
		desiredIn = '0;
		stepSize  = '0;
		zeroCheck = 1'b0;
		void'($urandom(32'h1d3e55fd));
		testReset();
		testIdentification();
		testZeroStep();
		testSparseEnable();
		testSaturation();
		testMidRunReset();
		totalErrors = checkErrors + localErrors;
		$display("Tests run %0d, failed %0d, errors %0d, results compared %0d",
			testsRun, failedTests, totalErrors, resultCount);
		if (totalErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/lmsFilterChecker.sv */
`default_nettype none

module lmsFilterChecker import lmsPkg::*; (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          enable,
	input  logic signed [SampleWidth-1:0] sampleIn,
	input  logic signed [SampleWidth-1:0] desiredIn,
	input  logic signed [SampleWidth-1:0] stepSize,
	input  logic signed [SampleWidth-1:0] filterOut,
	input  logic signed [SampleWidth-1:0] errorOut,
	input  logic                          outValid,
	input  logic                          zeroCheck,
	output int                            errorCount,
	output int                            resultCount
);

	timeunit 1ns;
	timeprecision 1ps;

	// Model state, tap k is fed by delays[k-1]
	longint weights [TapCount];
	longint delays  [TapCount];

	// Prediction for the result due one cycle after an enable
	logic                          armed      = 1'b0;
	logic                          justReset  = 1'b0;
	logic                          expValid   = 1'b0;
	logic                          expZero    = 1'b0;
	logic signed [SampleWidth-1:0] expFilter  = '0;
	logic signed [SampleWidth-1:0] expError   = '0;
	logic signed [SampleWidth-1:0] expDesired = '0;
	int                            errors     = 0;
	int                            results    = 0;

	assign errorCount  = errors;
	assign resultCount = results;

	function automatic longint clipSample(input longint value);
		if (value > longint'(SampleMax)) begin
			return longint'(SampleMax);
		end
		if (value < longint'(SampleMin)) begin
			return longint'(SampleMin);
		end
		return value;
	endfunction

	function automatic void clearModel();
		for (int k = 0; k < TapCount; k++) begin
			weights[k] = 0;
			delays[k]  = 0;
		end
	endfunction

	// One LMS iteration: output, error, then weight and delay update
	function automatic void modelSample(
		input  longint sample,
		input  longint desired,
		input  longint step,
		output longint filterVal,
		output longint errorVal
	);
		longint taps [TapCount];
		int     acc;
		longint mu;
		taps[0] = sample;
		for (int k = 1; k < TapCount; k++) begin
			taps[k] = delays[k-1];
		end
		// Partial sums wrap at 32 bits
		acc = 0;
		for (int k = 0; k < TapCount; k++) begin
			acc = acc + int'(weights[k] * taps[k]);
		end
		filterVal = clipSample(longint'(acc) >>> FracBits);
		errorVal  = clipSample(desired - filterVal);
		mu        = clipSample((step * errorVal) >>> FracBits);
		for (int k = 0; k < TapCount; k++) begin
			weights[k] = clipSample(weights[k] + ((mu * taps[k]) >>> FracBits));
			delays[k]  = taps[k];
		end
	endfunction

	function automatic void checkValue(
		input string                         name,
		input logic signed [SampleWidth-1:0] expected,
		input logic signed [SampleWidth-1:0] actual
	);
		if (actual !== expected) begin
			$display("Error: %s expected 0x%04h, got 0x%04h at %0t", name, expected, actual, $time);
			errors++;
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare at the falling edge, then predict the next rising edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		longint filterVal;
		longint errorVal;
		if (armed) begin
			if (outValid !== expValid) begin
				if (outValid === 1'b1) begin
					$display("outValid went high without an enable one cycle earlier");
				end else begin
					$display("outValid stayed low one cycle after an enable");
				end
				errors++;
			end else if (expValid) begin
				results++;
				checkValue("filterOut", expFilter, filterOut);
				checkValue("errorOut", expError, errorOut);
				// Zero weights pass desiredIn straight through
				if (expZero) begin
					checkValue("filterOut", '0, filterOut);
					checkValue("errorOut", expDesired, errorOut);
				end
			end
			if (justReset) begin
				checkValue("filterOut", '0, filterOut);
				checkValue("errorOut", '0, errorOut);
			end
		end
		justReset = 1'b0;
		expValid  = 1'b0;
		expZero   = 1'b0;
		if (rst) begin
			clearModel();
			armed     = 1'b1;
			justReset = 1'b1;
		end else if (enable) begin
			modelSample(longint'(sampleIn), longint'(desiredIn), longint'(stepSize),
				filterVal, errorVal);
			expValid   = 1'b1;
			expZero    = zeroCheck;
			expFilter  = filterVal[SampleWidth-1:0];
			expError   = errorVal[SampleWidth-1:0];
			expDesired = desiredIn;
		end
	end

endmodule

`default_nettype wire

/* design/lmsFilter.sv */
`default_nettype none

module lmsFilter import lmsPkg::*; (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          enable,
	input  logic signed [SampleWidth-1:0] sampleIn,
	input  logic signed [SampleWidth-1:0] desiredIn,
	input  logic signed [SampleWidth-1:0] stepSize,
	output logic signed [SampleWidth-1:0] filterOut,
	output logic signed [SampleWidth-1:0] errorOut,
	output logic                          outValid
);

	// Between the two groups
	logic signed [SampleWidth-1:0] groupZeroDelay;
	logic signed [SumWidth-1:0]    groupZeroSum;

	// Full 16-tap sum and the fed-back scaled error
	logic signed [SumWidth-1:0]    accSum;
	logic signed [SampleWidth-1:0] muErr;

	////////////////////////////////////////////////////////////////////////////
	// Taps 0 to 7
	////////////////////////////////////////////////////////////////////////////

	lmsTapGroup groupZero (
		.clk      (clk),
		.rst      (rst),
		.enable   (enable),
		.dataIn   (sampleIn),
		.muErr    (muErr),
		.sumIn    ('0),
		.sumOut   (groupZeroSum),
		.delayOut (groupZeroDelay)
	);

	////////////////////////////////////////////////////////////////////////////
	// Taps 8 to 15
	////////////////////////////////////////////////////////////////////////////

	// End of the delay line, nothing further down
	lmsTapGroup groupOne (
		.clk      (clk),
		.rst      (rst),
		.enable   (enable),
		.dataIn   (groupZeroDelay),
		.muErr    (muErr),
		.sumIn    (groupZeroSum),
		.sumOut   (accSum),
		.delayOut ()
	);

	////////////////////////////////////////////////////////////////////////////
	// Error and output stage
	////////////////////////////////////////////////////////////////////////////

	lmsErrorUnit errorUnit (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.sumIn     (accSum),
		.desiredIn (desiredIn),
		.stepSize  (stepSize),
		.muErr     (muErr),
		.filterOut (filterOut),
		.errorOut  (errorOut),
		.outValid  (outValid)
	);

endmodule

`default_nettype wire

/* design/lmsErrorUnit.sv */
`default_nettype none

module lmsErrorUnit import lmsPkg::*; (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          enable,
	input  logic signed [SumWidth-1:0]    sumIn,
	input  logic signed [SampleWidth-1:0] desiredIn,
	input  logic signed [SampleWidth-1:0] stepSize,
	output logic signed [SampleWidth-1:0] muErr,
	output logic signed [SampleWidth-1:0] filterOut,
	output logic signed [SampleWidth-1:0] errorOut,
	output logic                          outValid
);

	logic signed [SumWidth-1:0]    scaledSum;
	logic signed [SampleWidth-1:0] filterValue;
	logic signed [SumWidth-1:0]    errorWide;
	logic signed [SampleWidth-1:0] errorValue;
	logic signed [SumWidth-1:0]    stepProd;
	logic signed [SumWidth-1:0]    stepScaled;

	////////////////////////////////////////////////////////////////////////////
	// Error path, combinational so taps adapt on the same strobe
	////////////////////////////////////////////////////////////////////////////

	// Back to Q1.15, then clip
	assign scaledSum   = sumIn >>> FracBits;
	assign filterValue = satSample(scaledSum);

	// Difference can reach 17 bits
	assign errorWide  = desiredIn - filterValue;
	assign errorValue = satSample(errorWide);

	// mu * e, fed to every tap
	assign stepProd   = stepSize * errorValue;
	assign stepScaled = stepProd >>> FracBits;
	assign muErr      = satSample(stepScaled);

	////////////////////////////////////////////////////////////////////////////
	// Result registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			filterOut <= '0;
			errorOut  <= '0;
			outValid  <= 1'b0;
		end else begin
			outValid <= enable;
			if (enable) begin
				filterOut <= filterValue;
				errorOut  <= errorValue;
			end
		end
	end

	// Each result belongs to the strobe one cycle earlier
	property validAfterEnable;
		@(posedge clk) disable iff (rst)
		outValid |-> $past(enable);
	endproperty

	assert property (validAfterEnable)
		else $error("lmsErrorUnit: outValid without preceding enable");

endmodule

`default_nettype wire

/* design/lmsTapGroup.sv */
`default_nettype none

module lmsTapGroup import lmsPkg::*; (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          enable,
	input  logic signed [SampleWidth-1:0] dataIn,
	input  logic signed [SampleWidth-1:0] muErr,
	input  logic signed [SumWidth-1:0]    sumIn,
	output logic signed [SumWidth-1:0]    sumOut,
	output logic signed [SampleWidth-1:0] delayOut
);

	// Entry i feeds tap i and entry i+1 is its delay register
	logic signed [SampleWidth-1:0] delayChain [TapsPerGroup+1];

	// One product per tap
	logic signed [SumWidth-1:0] tapProducts [TapsPerGroup];

	assign delayChain[0] = dataIn;

	////////////////////////////////////////////////////////////////////////////
	// Tap chain
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < TapsPerGroup; i++) begin : genTap
		lmsTap tap (
			.clk      (clk),
			.rst      (rst),
			.enable   (enable),
			.dataIn   (delayChain[i]),
			.muErr    (muErr),
			.delayOut (delayChain[i+1]),
			.tapOut   (tapProducts[i])
		);
	end

	// Last delay register hands over to the next group
	assign delayOut = delayChain[TapsPerGroup];

	////////////////////////////////////////////////////////////////////////////
	// Partial sum
	////////////////////////////////////////////////////////////////////////////

	// Products add with a plain 32-bit wrap
	always_comb begin
		sumOut = sumIn;
		for (int i = 0; i < TapsPerGroup; i++) begin
			sumOut = sumOut + tapProducts[i];
		end
	end

endmodule

`default_nettype wire

/* design/lmsTap.sv */
`default_nettype none

module lmsTap import lmsPkg::*; (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          enable,
	input  logic signed [SampleWidth-1:0] dataIn,
	input  logic signed [SampleWidth-1:0] muErr,
	output logic signed [SampleWidth-1:0] delayOut,
	output logic signed [SumWidth-1:0]    tapOut
);

	// Adaptive coefficient and one-sample delay
	logic signed [SampleWidth-1:0] weight;
	logic signed [SampleWidth-1:0] delayReg;

	// Update path
	logic signed [SumWidth-1:0]    gradProd;
	logic signed [SumWidth-1:0]    weightStep;
	logic signed [SumWidth-1:0]    weightSum;
	logic signed [SampleWidth-1:0] weightNext;

	////////////////////////////////////////////////////////////////////////////
	// Filter product
	////////////////////////////////////////////////////////////////////////////

	// Full 32-bit product, never overflows for Q1.15 operands
	assign tapOut = weight * dataIn;

	assign delayOut = delayReg;

	////////////////////////////////////////////////////////////////////////////
	// LMS weight update
	////////////////////////////////////////////////////////////////////////////

	// Gradient estimate scaled back to Q1.15
	assign gradProd   = muErr * dataIn;
	assign weightStep = gradProd >>> FracBits;

	// Step is at most 17 significant bits, sum fits easily
	assign weightSum  = weight + weightStep;
	assign weightNext = satSample(weightSum);

	always_ff @(posedge clk) begin
		if (rst) begin
			weight   <= '0;
			delayReg <= '0;
		end else if (enable) begin
			weight   <= weightNext;
			delayReg <= dataIn;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Coefficient only moves on a sample strobe
	property weightHoldsIdle;
		@(posedge clk) disable iff (rst)
		!enable |=> $stable(weight);
	endproperty

	// Delay line starts empty after reset
	property delayClearedByReset;
		@(posedge clk)
		rst |=> (delayOut == '0);
	endproperty

	assert property (weightHoldsIdle)
		else $error("lmsTap: weight changed without enable");

	assert property (delayClearedByReset)
		else $error("lmsTap: delay register not cleared by reset");

endmodule

`default_nettype wire

/* design/lmsPkg.sv */
`default_nettype none

package lmsPkg;

	////////////////////////////////////////////////////////////////////////////
	// Word formats
	////////////////////////////////////////////////////////////////////////////

	// Samples, weights, step size and scaled error
	localparam int SampleWidth = 16;

	// Tap products and running partial sums
	localparam int SumWidth = 32;

	// Q1.15
	localparam int FracBits = 15;

	////////////////////////////////////////////////////////////////////////////
	// Filter geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int TapsPerGroup = 8;
	localparam int GroupCount   = 2;
	localparam int TapCount     = TapsPerGroup * GroupCount;

	// Clip bounds of a signed sample word
	localparam logic signed [SampleWidth-1:0] SampleMax = {1'b0, {(SampleWidth-1){1'b1}}};
	localparam logic signed [SampleWidth-1:0] SampleMin = {1'b1, {(SampleWidth-1){1'b0}}};

	// Clip a wide signed value into sample range
	function automatic logic signed [SampleWidth-1:0] satSample(
		input logic signed [SumWidth-1:0] value
	);
		if (value > SampleMax) begin
			return SampleMax;
		end else if (value < SampleMin) begin
			return SampleMin;
		end
		return value[SampleWidth-1:0];
	endfunction

endpackage

`default_nettype wire
